/* src/rv_isa_pkg.sv */
// RV64IM ISA constants: register width, major opcodes, funct7 values, field positions
package rv_isa_pkg;

    parameter int XLEN_DEFAULT = 64;

    typedef logic [4:0] reg_idx_t;

    // Major opcodes, instruction bits 6..0
    typedef enum logic [6:0] {
        OP        = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_32     = 7'b0111011,
        OP_IMM_32 = 7'b0011011,
        LOAD      = 7'b0000011,
        STORE     = 7'b0100011,
        BRANCH    = 7'b1100011,
        JAL       = 7'b1101111,
        JALR      = 7'b1100111,
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111,
        SYSTEM    = 7'b1110011,
        MISC_MEM  = 7'b0001111
    } opcode_e;

    parameter logic [6:0] FUNCT7_BASE   = 7'b0000000;
    parameter logic [6:0] FUNCT7_ALT    = 7'b0100000; // SUB and arithmetic shifts
    parameter logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // Bits 31..20 of the two environment calls
    parameter logic [11:0] SYS_IMM_ECALL  = 12'h000;
    parameter logic [11:0] SYS_IMM_EBREAK = 12'h001;

    // Low bit of each fixed field
    parameter int OPCODE_LSB = 0;
    parameter int RD_LSB     = 7;
    parameter int FUNCT3_LSB = 12;
    parameter int RS1_LSB    = 15;
    parameter int RS2_LSB    = 20;
    parameter int FUNCT7_LSB = 25;

endpackage

/* src/decode_pkg.sv */
// Decoder result types: instruction format and instruction kind
package decode_pkg;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_FENCE,
        FMT_NONE
    } insn_format_e;

    // Numbering is fixed, downstream logic compares raw codes
    typedef enum logic [7:0] {
        ADD    = 8'd0,  SUB    = 8'd1,  XOR    = 8'd2,  OR     = 8'd3,
        AND    = 8'd4,  SLL    = 8'd5,  SRL    = 8'd6,  SRA    = 8'd7,
        SLT    = 8'd8,  SLTU   = 8'd9,
        MUL    = 8'd10, MULH   = 8'd11, MULHSU = 8'd12, MULHU  = 8'd13,
        DIV    = 8'd14, DIVU   = 8'd15, REM    = 8'd16, REMU   = 8'd17,
        ADDI   = 8'd18, XORI   = 8'd19, ORI    = 8'd20, ANDI   = 8'd21,
        SLLI   = 8'd22, SRLI   = 8'd23, SRAI   = 8'd24, SLTI   = 8'd25,
        SLTIU  = 8'd26,
        ADDIW  = 8'd29, SLLIW  = 8'd30, SRLIW  = 8'd31, SRAIW  = 8'd32,
        ADDW   = 8'd33, SUBW   = 8'd34, SLLW   = 8'd35, SRLW   = 8'd36,
        SRAW   = 8'd37, MULW   = 8'd38, DIVW   = 8'd39, DIVUW  = 8'd40,
        REMW   = 8'd41, REMUW  = 8'd42,
        SB     = 8'd43, SH     = 8'd44, SW     = 8'd45, SD     = 8'd46,
        BEQ    = 8'd47, BNE    = 8'd48, BLT    = 8'd49, BGE    = 8'd50,
        BLTU   = 8'd51, BGEU   = 8'd52,
        JAL    = 8'd53, JALR   = 8'd54, LUI    = 8'd55, AUIPC  = 8'd56,
        ECALL  = 8'd57, EBREAK = 8'd58,
        LB     = 8'd59, LH     = 8'd60, LW     = 8'd61, LBU    = 8'd62,
        LHU    = 8'd63, LWU    = 8'd64, LD     = 8'd65,
        FENCE  = 8'd66,
        UNKNOWN = 8'd255
    } insn_kind_e;

endpackage

/* src/decode_bus_if.sv */
// Interface carrying split instruction fields and format between decode stages
`timescale 1ns/1ps

interface decode_bus_if
    import rv_isa_pkg::*, decode_pkg::*;
();

    logic [31:0]  instr;
    opcode_e      opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    reg_idx_t     rd;
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    insn_format_e format;

    modport source (
        output instr, opcode, funct3, funct7, rd, rs1, rs2, format
    );

    modport sink (
        input instr, opcode, funct3, funct7, rd, rs1, rs2, format
    );

endinterface

/* src/format_decoder.sv */
// Field extraction and format selection from the opcode
`timescale 1ns/1ps

module format_decoder
    import rv_isa_pkg::*, decode_pkg::*;
(
    input  logic [31:0]         instr,
    decode_bus_if.source        bus
);

    opcode_e      opc;
    insn_format_e fmt;

    assign opc = opcode_e'(instr[OPCODE_LSB +: 7]);

    always_comb begin
        case (opc)
            OP, OP_32:                         fmt = FMT_R;
            OP_IMM, OP_IMM_32, LOAD, SYSTEM:   fmt = FMT_I;
            rv_isa_pkg::JALR:                  fmt = FMT_I;
            STORE:                             fmt = FMT_S;
            BRANCH:                            fmt = FMT_B;
            rv_isa_pkg::LUI, rv_isa_pkg::AUIPC: fmt = FMT_U;
            rv_isa_pkg::JAL:                   fmt = FMT_J;
            MISC_MEM:                          fmt = FMT_FENCE;
            default:                           fmt = FMT_NONE; // opcode 0 lands here
        endcase
    end

    assign bus.instr  = instr;
    assign bus.opcode = opc;
    assign bus.funct3 = instr[FUNCT3_LSB +: 3];
    assign bus.funct7 = instr[FUNCT7_LSB +: 7];
    assign bus.format = fmt;

    // Zero the register fields a format leaves unused
    always_comb begin
        bus.rd  = instr[RD_LSB +: 5];
        bus.rs1 = instr[RS1_LSB +: 5];
        bus.rs2 = instr[RS2_LSB +: 5];
        case (fmt)
            FMT_S, FMT_B: bus.rd = '0;
            FMT_U, FMT_J: begin
                bus.rs1 = '0;
                bus.rs2 = '0;
            end
            FMT_I, FMT_FENCE: bus.rs2 = '0; // Fence bits 24..20 hold succ
            FMT_NONE: begin
                bus.rd  = '0;
                bus.rs1 = '0;
                bus.rs2 = '0;
            end
            default: ;
        endcase
    end

endmodule

/* src/insn_classifier.sv */
// Instruction kind classification from opcode, funct3, funct7 and system bits
`timescale 1ns/1ps

module insn_classifier
    import rv_isa_pkg::*, decode_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    decode_bus_if.sink          bus,
    output insn_kind_e          kind
);

    localparam bit HAS_W_OPS = (XLEN > 32); // W and IW only exist on RV64

    logic [5:0] imm_hi; // Bits 31..26, selects logical or arithmetic shift

    assign imm_hi = bus.instr[31:26];

    always_comb begin
        kind = UNKNOWN;
        case (bus.opcode)
            OP: begin
                if (bus.funct7 == FUNCT7_MULDIV) begin
                    case (bus.funct3)
                        3'd0: kind = MUL;
                        3'd1: kind = MULH;
                        3'd2: kind = MULHSU;
                        3'd3: kind = MULHU;
                        3'd4: kind = DIV;
                        3'd5: kind = DIVU;
                        3'd6: kind = REM;
                        3'd7: kind = REMU;
                    endcase
                end else if (bus.funct7 == FUNCT7_BASE) begin
                    case (bus.funct3)
                        3'd0: kind = ADD;
                        3'd1: kind = SLL;
                        3'd2: kind = SLT;
                        3'd3: kind = SLTU;
                        3'd4: kind = XOR;
                        3'd5: kind = SRL;
                        3'd6: kind = OR;
                        3'd7: kind = AND;
                    endcase
                end else if (bus.funct7 == FUNCT7_ALT) begin
                    if (bus.funct3 == 3'd0)
                        kind = SUB;
                    else if (bus.funct3 == 3'd5)
                        kind = SRA;
                end
            end
            OP_IMM: begin
                case (bus.funct3)
                    3'd0: kind = ADDI;
                    3'd1: kind = (imm_hi == 6'b000000) ? SLLI : UNKNOWN;
                    3'd2: kind = SLTI;
                    3'd3: kind = SLTIU;
                    3'd4: kind = XORI;
                    3'd5: begin
                        if (imm_hi == 6'b000000)
                            kind = SRLI;
                        else if (imm_hi == 6'b010000)
                            kind = SRAI;
                    end
                    3'd6: kind = ORI;
                    3'd7: kind = ANDI;
                endcase
            end
            OP_32: begin
                if (HAS_W_OPS) begin
                    if (bus.funct7 == FUNCT7_MULDIV) begin
                        case (bus.funct3)
                            3'd0: kind = MULW;
                            3'd4: kind = DIVW;
                            3'd5: kind = DIVUW;
                            3'd6: kind = REMW;
                            3'd7: kind = REMUW;
                            default: ;
                        endcase
                    end else if (bus.funct7 == FUNCT7_BASE) begin
                        case (bus.funct3)
                            3'd0: kind = ADDW;
                            3'd1: kind = SLLW;
                            3'd5: kind = SRLW;
                            default: ;
                        endcase
                    end else if (bus.funct7 == FUNCT7_ALT) begin
                        if (bus.funct3 == 3'd0)
                            kind = SUBW;
                        else if (bus.funct3 == 3'd5)
                            kind = SRAW;
                    end
                end
            end
            OP_IMM_32: begin
                if (HAS_W_OPS) begin
                    if (bus.funct3 == 3'd0)
                        kind = ADDIW;
                    else if (bus.funct3 == 3'd1 && bus.funct7 == FUNCT7_BASE)
                        kind = SLLIW;
                    else if (bus.funct3 == 3'd5 && bus.funct7 == FUNCT7_BASE)
                        kind = SRLIW;
                    else if (bus.funct3 == 3'd5 && bus.funct7 == FUNCT7_ALT)
                        kind = SRAIW;
                end
            end
            LOAD: begin
                case (bus.funct3)
                    3'd0: kind = LB;
                    3'd1: kind = LH;
                    3'd2: kind = LW;
                    3'd3: kind = LD;
                    3'd4: kind = LBU;
                    3'd5: kind = LHU;
                    3'd6: kind = LWU;
                    default: ;
                endcase
            end
            STORE: begin
                case (bus.funct3)
                    3'd0: kind = SB;
                    3'd1: kind = SH;
                    3'd2: kind = SW;
                    3'd3: kind = SD;
                    default: ;
                endcase
            end
            BRANCH: begin
                case (bus.funct3)
                    3'd0: kind = BEQ;
                    3'd1: kind = BNE;
                    3'd4: kind = BLT;
                    3'd5: kind = BGE;
                    3'd6: kind = BLTU;
                    3'd7: kind = BGEU;
                    default: ;
                endcase
            end
            rv_isa_pkg::JAL:   kind = decode_pkg::JAL;
            rv_isa_pkg::JALR:  kind = (bus.funct3 == 3'd0) ? decode_pkg::JALR : UNKNOWN;
            rv_isa_pkg::LUI:   kind = decode_pkg::LUI;
            rv_isa_pkg::AUIPC: kind = decode_pkg::AUIPC;
            SYSTEM: begin
                // rd, funct3 and rs1 must all be zero
                if (bus.instr[19:7] == 13'd0) begin
                    if (bus.instr[31:20] == SYS_IMM_ECALL)
                        kind = ECALL;
                    else if (bus.instr[31:20] == SYS_IMM_EBREAK)
                        kind = EBREAK;
                end
            end
            MISC_MEM: kind = (bus.funct3 == 3'd0) ? FENCE : UNKNOWN;
            default: kind = UNKNOWN;
        endcase
    end

    // A clean opcode must never leave the kind undefined
    kind_known_a: assert final ($isunknown(bus.instr) || !$isunknown(kind));

endmodule

/* src/imm_generator.sv */
// Immediate assembly, shift amount and fence ordering fields
`timescale 1ns/1ps

module imm_generator
    import rv_isa_pkg::*, decode_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    decode_bus_if.sink              bus,
    output logic signed [XLEN-1:0]  imm,
    output logic [5:0]              shamt,
    output logic [3:0]              pred,
    output logic [3:0]              succ
);

    logic [31:0]        i;
    logic signed [31:0] imm32; // Every format fits in 32 bits before extension

    assign i = bus.instr;

    always_comb begin
        case (bus.format)
            FMT_I:   imm32 = {{20{i[31]}}, i[31:20]};
            FMT_S:   imm32 = {{20{i[31]}}, i[31:25], i[11:7]};
            FMT_B:   imm32 = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
            FMT_U:   imm32 = {i[31:12], 12'b0};
            FMT_J:   imm32 = {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
            default: imm32 = '0; // R, fence and unknown
        endcase
    end

    assign imm = XLEN'(imm32); // Signed cast widens with the sign bit

    always_comb begin
        case (bus.opcode)
            OP_IMM:    shamt = i[25:20];
            OP_IMM_32: shamt = {1'b0, i[24:20]};
            default:   shamt = '0;
        endcase
    end

    assign pred = (bus.format == FMT_FENCE) ? i[27:24] : 4'd0;
    assign succ = (bus.format == FMT_FENCE) ? i[23:20] : 4'd0;

    // Word shifts are limited to 31
    shamt_w_a: assert final (bus.opcode != OP_IMM_32 || !shamt[5]);

endmodule

/* src/decode_output_reg.sv */
// Output register stage for all decode results and the complete strobe
`timescale 1ns/1ps

module decode_output_reg
    import rv_isa_pkg::*, decode_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    decode_enable,
    input  logic [6:0]              opcode_d,
    input  reg_idx_t                rd_d,
    input  reg_idx_t                rs1_d,
    input  reg_idx_t                rs2_d,
    input  insn_kind_e              kind_d,
    input  logic signed [XLEN-1:0]  imm_d,
    input  logic [5:0]              shamt_d,
    input  logic [3:0]              pred_d,
    input  logic [3:0]              succ_d,
    output logic [6:0]              opcode_q,
    output reg_idx_t                rd_q,
    output reg_idx_t                rs1_q,
    output reg_idx_t                rs2_q,
    output insn_kind_e              kind_q,
    output logic signed [XLEN-1:0]  imm_q,
    output logic [5:0]              shamt_q,
    output logic [3:0]              pred_q,
    output logic [3:0]              succ_q,
    output logic                    decode_complete
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decode_complete <= 1'b0;
            opcode_q        <= '0;
            rd_q            <= '0;
            rs1_q           <= '0;
            rs2_q           <= '0;
            kind_q          <= UNKNOWN;
            imm_q           <= '0;
            shamt_q         <= '0;
            pred_q          <= '0;
            succ_q          <= '0;
        end else begin
            decode_complete <= decode_enable; // One pulse per accepted word
            if (decode_enable) begin
                opcode_q <= opcode_d;
                rd_q     <= rd_d;
                rs1_q    <= rs1_d;
                rs2_q    <= rs2_d;
                kind_q   <= kind_d;
                imm_q    <= imm_d;
                shamt_q  <= shamt_d;
                pred_q   <= pred_d;
                succ_q   <= succ_d;
            end
        end
    end

    // Complete trails enable by exactly one cycle
    complete_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> decode_complete == $past(decode_enable));

    kind_defined_a: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(kind_q));

endmodule

/* src/rv_decoder_top.sv */
// RV64IM decoder top level with plain ports over the decode stages
`timescale 1ns/1ps

module rv_decoder_top
    import rv_isa_pkg::*, decode_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             instruction,
    input  logic                    decode_enable,
    output logic [6:0]              opcode,
    output reg_idx_t                rd,
    output reg_idx_t                rs1,
    output reg_idx_t                rs2,
    output logic signed [XLEN-1:0]  imm,
    output logic [5:0]              shamt,
    output insn_kind_e              instruction_type,
    output logic [3:0]              pred,
    output logic [3:0]              succ,
    output logic                    decode_complete
);

    decode_bus_if bus ();

    insn_kind_e             kind;
    logic signed [XLEN-1:0] imm_comb;
    logic [5:0]             shamt_comb;
    logic [3:0]             pred_comb;
    logic [3:0]             succ_comb;

    format_decoder u_format (
        .instr (instruction),
        .bus   (bus)
    );

    insn_classifier #(.XLEN(XLEN)) u_classify (
        .bus  (bus),
        .kind (kind)
    );

    imm_generator #(.XLEN(XLEN)) u_imm (
        .bus   (bus),
        .imm   (imm_comb),
        .shamt (shamt_comb),
        .pred  (pred_comb),
        .succ  (succ_comb)
    );

    decode_output_reg #(.XLEN(XLEN)) u_out (
        .clk             (clk),
        .rst_n           (rst_n),
        .decode_enable   (decode_enable),
        .opcode_d        (bus.opcode),
        .rd_d            (bus.rd),
        .rs1_d           (bus.rs1),
        .rs2_d           (bus.rs2),
        .kind_d          (kind),
        .imm_d           (imm_comb),
        .shamt_d         (shamt_comb),
        .pred_d          (pred_comb),
        .succ_d          (succ_comb),
        .opcode_q        (opcode),
        .rd_q            (rd),
        .rs1_q           (rs1),
        .rs2_q           (rs2),
        .kind_q          (instruction_type),
        .imm_q           (imm),
        .shamt_q         (shamt),
        .pred_q          (pred),
        .succ_q          (succ),
        .decode_complete (decode_complete)
    );

endmodule

/* tests/decoder_model.svh */
// Decoder reference model: legal opcode table, kind tables, immediate, shamt and register use
`ifndef DECODER_MODEL_SVH
`define DECODER_MODEL_SVH

// Major opcodes straight from the ISA encoding tables
localparam logic [6:0] LEGAL_OPC [13] = '{7'h33, 7'h13, 7'h3B, 7'h1B, 7'h03, 7'h23, 7'h63,
                                          7'h6F, 7'h67, 7'h37, 7'h17, 7'h73, 7'h0F};
localparam logic [6:0] FUNCT7_PICK [3] = '{7'h00, 7'h01, 7'h20};

// Kinds indexed by funct3
localparam insn_kind_e OP_BASE_K [8]  = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
localparam insn_kind_e OP_MUL_K [8]   = '{MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU};
localparam insn_kind_e OP_ALT_K [8]   = '{SUB, UNKNOWN, UNKNOWN, UNKNOWN,
                                          UNKNOWN, SRA, UNKNOWN, UNKNOWN};
localparam insn_kind_e OPW_BASE_K [8] = '{ADDW, SLLW, UNKNOWN, UNKNOWN,
                                          UNKNOWN, SRLW, UNKNOWN, UNKNOWN};
localparam insn_kind_e OPW_MUL_K [8]  = '{MULW, UNKNOWN, UNKNOWN, UNKNOWN,
                                          DIVW, DIVUW, REMW, REMUW};
localparam insn_kind_e OPW_ALT_K [8]  = '{SUBW, UNKNOWN, UNKNOWN, UNKNOWN,
                                          UNKNOWN, SRAW, UNKNOWN, UNKNOWN};
localparam insn_kind_e IMM_K [8]      = '{ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, ORI, ANDI};
localparam insn_kind_e LOAD_K [8]     = '{LB, LH, LW, LD, LBU, LHU, LWU, UNKNOWN};
localparam insn_kind_e STORE_K [8]    = '{SB, SH, SW, SD, UNKNOWN, UNKNOWN, UNKNOWN, UNKNOWN};
localparam insn_kind_e BRANCH_K [8]   = '{BEQ, BNE, UNKNOWN, UNKNOWN, BLT, BGE, BLTU, BGEU};

function automatic insn_kind_e model_kind(input logic [31:0] w);
    logic [6:0] f7;
    logic [2:0] f3;
    logic       wide;
    f7   = w[31:25];
    f3   = w[14:12];
    wide = (w[6:0] == 7'h3B);
    case (w[6:0])
        7'h33, 7'h3B: begin
            case (f7)
                7'h00:   return wide ? OPW_BASE_K[f3] : OP_BASE_K[f3];
                7'h01:   return wide ? OPW_MUL_K[f3] : OP_MUL_K[f3];
                7'h20:   return wide ? OPW_ALT_K[f3] : OP_ALT_K[f3];
                default: return UNKNOWN;
            endcase
        end
        7'h13: begin
            if (f3 == 3'd5 && w[31:26] == 6'b010000)
                return SRAI;
            if ((f3 == 3'd1 || f3 == 3'd5) && w[31:26] != 6'b000000)
                return UNKNOWN;
            return IMM_K[f3];
        end
        7'h1B: begin
            if (f3 == 3'd0)
                return ADDIW;
            if (f3 == 3'd1 && f7 == 7'h00)
                return SLLIW;
            if (f3 == 3'd5 && f7 == 7'h00)
                return SRLIW;
            if (f3 == 3'd5 && f7 == 7'h20)
                return SRAIW;
            return UNKNOWN;
        end
        7'h03: return LOAD_K[f3];
        7'h23: return STORE_K[f3];
        7'h63: return BRANCH_K[f3];
        7'h6F: return decode_pkg::JAL;
        7'h67: return (f3 == 3'd0) ? decode_pkg::JALR : UNKNOWN;
        7'h37: return decode_pkg::LUI;
        7'h17: return decode_pkg::AUIPC;
        7'h73: begin
            if (w[19:7] != 13'd0) // rd, funct3 and rs1 all zero
                return UNKNOWN;
            if (w[31:20] == 12'd0)
                return ECALL;
            if (w[31:20] == 12'd1)
                return EBREAK;
            return UNKNOWN;
        end
        7'h0F:   return (f3 == 3'd0) ? FENCE : UNKNOWN;
        default: return UNKNOWN;
    endcase
endfunction

// Shift up then arithmetic shift down to replicate the top bit
function automatic longint sign_extend(input logic [31:0] raw, input int width);
    longint v;
    v = longint'(raw) <<< (64 - width);
    return v >>> (64 - width);
endfunction

function automatic longint model_imm(input logic [31:0] w);
    case (w[6:0])
        7'h13, 7'h1B, 7'h03, 7'h67, 7'h73: return sign_extend(w[31:20], 12);
        7'h23:         return sign_extend({w[31:25], w[11:7]}, 12);
        7'h63:         return sign_extend({w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
        7'h37, 7'h17:  return sign_extend({w[31:12], 12'b0}, 32);
        7'h6F:         return sign_extend({w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
        default:       return 0; // R, fence and illegal opcodes
    endcase
endfunction

function automatic logic [5:0] model_shamt(input logic [31:0] w);
    if (w[6:0] == 7'h13)
        return w[25:20];
    if (w[6:0] == 7'h1B)
        return {1'b0, w[24:20]};
    return 6'd0;
endfunction

// Which of rd, rs1 and rs2 an opcode carries
function automatic logic [2:0] model_reg_use(input logic [6:0] opc);
    case (opc)
        7'h33, 7'h3B:                             return 3'b111;
        7'h13, 7'h1B, 7'h03, 7'h67, 7'h73, 7'h0F: return 3'b110;
        7'h23, 7'h63:                             return 3'b011;
        7'h37, 7'h17, 7'h6F:                      return 3'b100;
        default:                                  return 3'b000;
    endcase
endfunction

`endif

/* tests/tb_rv_decoder.sv */
// Testbench for the RV64IM decoder: reset, random words, model check, watchdog, summary
`timescale 1ns/1ps

module tb_rv_decoder
    import rv_isa_pkg::*, decode_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_RANDOM   = 3000;
    localparam int NUM_DIRECTED = 10;
    localparam int TIMEOUT_NS   = (NUM_DIRECTED + NUM_RANDOM + RESET_CYCLES + 4) * CLK_PERIOD + 500;

    localparam logic [31:0] DIRECTED_WORDS [NUM_DIRECTED] = '{
        32'h0000_0000,  // Opcode 0 is illegal
        32'h0000_0073,  // ECALL
        32'h0010_0073,  // EBREAK
        32'h0020_0073,  // System imm 2
        32'h0000_00f3,  // ECALL pattern with rd set
        32'h0020_c1b3,  // XOR x3, x1, x2
        32'h0020_e1b3,  // OR
        32'h0020_f1b3,  // AND
        32'h0020_91b3,  // SLL
        32'h0ff0_000f   // FENCE iorw, iorw
    };

    logic               clk;
    logic               rst_n;
    logic [31:0]        instruction;
    logic               decode_enable;
    logic [6:0]         opcode;
    reg_idx_t           rd;
    reg_idx_t           rs1;
    reg_idx_t           rs2;
    logic signed [63:0] imm;
    logic [5:0]         shamt;
    insn_kind_e         instruction_type;
    logic [3:0]         pred;
    logic [3:0]         succ;
    logic               decode_complete;

    logic [31:0] last_word; // Driven at the previous edge
    logic        last_en;
    logic [31:0] exp_word;  // Last word the DUT took in
    logic        exp_complete;
    logic [6:0]  exp_opcode;
    logic [14:0] exp_regs;  // {rd, rs1, rs2}
    insn_kind_e  exp_kind;
    longint      exp_imm;
    logic [5:0]  exp_shamt;
    logic [7:0]  exp_fence; // {pred, succ}
    logic [31:0] rng_state;
    int          errors;
    int          checks;

    rv_decoder_top #(.XLEN(XLEN_DEFAULT)) DUT (.*);

    `include "decoder_model.svh"

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Upper halves only, the low LCG bits cycle quickly
    function automatic logic [31:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[31:16], lo[31:16]};
    endfunction

    function automatic logic [31:0] legal_word();
        logic [31:0] w;
        logic [31:0] r;
        for (int tries = 0; tries < 16; tries++) begin
            w = rand_word();
            r = next_rand();
            w[6:0] = LEGAL_OPC[(r >> 16) % 13];
            case (w[6:0])
                7'h33, 7'h3B: w[31:25] = FUNCT7_PICK[(r >> 8) % 3];
                7'h13, 7'h1B: begin
                    if (w[13:12] == 2'b01) // Shift ops, funct3 1 or 5
                        w[31:25] = FUNCT7_PICK[(r >> 8) % 3];
                end
                7'h67, 7'h0F: w[14:12] = 3'd0;
                7'h73:        w[31:7] = {11'd0, r[12], 13'd0};
                default: ;
            endcase
            if (model_kind(w) != UNKNOWN)
                return w;
        end
        return w;
    endfunction

    task automatic capture_expected(input logic [31:0] w, input logic en);
        logic [2:0] use_regs;
        exp_complete = en;
        if (en) begin
            use_regs   = model_reg_use(w[6:0]);
            exp_word   = w;
            exp_opcode = w[6:0];
            exp_kind   = model_kind(w);
            exp_imm    = model_imm(w);
            exp_shamt  = model_shamt(w);
            exp_regs   = {use_regs[2] ? w[11:7] : 5'd0, use_regs[1] ? w[19:15] : 5'd0,
                          use_regs[0] ? w[24:20] : 5'd0};
            exp_fence  = (w[6:0] == 7'h0F) ? w[27:20] : 8'd0;
        end
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error %0t: %s is %h, expected %h for word %h",
                     $time, what, got, exp, exp_word);
        end
    endtask

    task automatic check_outputs();
        check_value("decode_complete", decode_complete, exp_complete);
        check_value("opcode", opcode, exp_opcode);
        check_value("rd", rd, exp_regs[14:10]);
        check_value("rs1", rs1, exp_regs[9:5]);
        check_value("rs2", rs2, exp_regs[4:0]);
        check_value("instruction_type", instruction_type, exp_kind);
        check_value("imm", imm, exp_imm);
        check_value("shamt", shamt, exp_shamt);
        check_value("pred", pred, exp_fence[7:4]);
        check_value("succ", succ, exp_fence[3:0]);
    endtask

    // One cycle: the DUT takes last cycle's word at this edge, results checked mid-cycle
    task automatic step(input logic [31:0] w, input logic en);
        @(posedge clk);
        capture_expected(last_word, last_en);
        instruction   <= w;
        decode_enable <= en;
        last_word = w;
        last_en   = en;
        @(negedge clk);
        check_outputs();
    endtask

    initial begin
        logic [31:0] w;
        logic [31:0] r;
        rng_state     = 32'h90ff_20f6;
        errors        = 0;
        checks        = 0;
        rst_n         = 1'b0;
        instruction   = '0;
        decode_enable = 1'b0;
        last_word     = '0;
        last_en       = 1'b0;
        exp_word      = '0;
        exp_complete  = 1'b0;
        exp_opcode    = '0;
        exp_regs      = '0;
        exp_kind      = UNKNOWN;
        exp_imm       = 0;
        exp_shamt     = '0;
        exp_fence     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_outputs(); // Reset values
        for (int i = 0; i < NUM_DIRECTED; i++)
            step(DIRECTED_WORDS[i], 1'b1); // Back to back
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r = next_rand();
            w = ((r >> 16) % 5 == 0) ? rand_word() : legal_word();
            r = next_rand();
            step(w, ((r >> 16) % 4) != 0);
        end
        step('0, 1'b0); // Flush the last word
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired at %0t before the run finished, checks %0d, errors %0d",
                 $time, checks, errors);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* src.f */
+incdir+tests
src/rv_isa_pkg.sv
src/decode_pkg.sv
src/decode_bus_if.sv
src/format_decoder.sv
src/insn_classifier.sv
src/imm_generator.sv
src/decode_output_reg.sv
src/rv_decoder_top.sv
tests/tb_rv_decoder.sv
